/* mgmt_pkg.sv */
`default_nettype none

package mgmt_pkg;

	// Host register offsets
	localparam logic [15:0] ADDR_MDIC = 16'h0020;
	localparam logic [15:0] ADDR_ICR  = 16'h00C0;
	localparam logic [15:0] ADDR_IMS  = 16'h00D0;
	localparam logic [15:0] ADDR_IMC  = 16'h00D8;

	localparam int CAUSE_MDAC   = 9;  // MDIO access done
	localparam int CAUSE_PHYINT = 12;

	localparam logic [1:0] MDIO_ST    = 2'b01;
	localparam logic [1:0] MDIO_TA    = 2'b10;
	localparam logic [1:0] MDIO_OP_WR = 2'b01;
	localparam logic [1:0] MDIO_OP_RD = 2'b10;

	typedef struct packed {
		logic        wr;
		logic        rd;
		logic [15:0] addr;
		logic [31:0] wdata;
	} host_req_t;

	typedef struct packed {
		logic        spare;
		logic        err;
		logic        int_en;
		logic        ready;
		logic [1:0]  op;
		logic [4:0]  phyad;
		logic [4:0]  regad;
		logic [15:0] data;
	} mdic_t;

	// Clause 22 frame after the preamble
	typedef struct packed {
		logic [1:0]  st;
		logic [1:0]  op;
		logic [4:0]  phyad;
		logic [4:0]  regad;
		logic [1:0]  ta;
		logic [15:0] data;
	} mdio_fields_t;

	typedef union packed {
		mdio_fields_t f;
		logic [31:0]  raw;  // Shifted out MSB first
	} mdio_frame_u;

	typedef struct packed {
		logic        start;
		mdio_frame_u frame;
	} mdio_cmd_t;

endpackage

`default_nettype wire

/* mgmt_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module mgmt_regs #(
	parameter logic [4:0] PHY_ADDR = 5'h00
) (
	input  wire logic                aclk,
	input  wire logic                rst_n_i,
	input  wire mgmt_pkg::host_req_t host_i,
	output logic [31:0]              rdata_o,
	output mgmt_pkg::mdio_cmd_t      cmd_o,
	input  wire logic                busy_i,
	input  wire logic                done_i,
	input  wire logic [15:0]         rd_data_i,
	input  wire logic [31:0]         icr_i,
	input  wire logic [31:0]         ims_i,
	output logic                     icr_rd_o,
	output logic                     ims_wr_o,
	output logic                     imc_wr_o,
	output logic [31:0]              wdata_o
);
	import mgmt_pkg::*;

	mdic_t mdic;
	mdic_t mdic_wr;
	logic  mdic_accept;
	logic  start_q;

	assign mdic_wr = host_i.wdata;

	// Only one frame at a time, ready stays low until done
	assign mdic_accept = host_i.wr && host_i.addr == ADDR_MDIC && !busy_i && mdic.ready &&
		(mdic_wr.op == MDIO_OP_WR || mdic_wr.op == MDIO_OP_RD);

	always_ff @(posedge aclk) begin
		if (!rst_n_i) begin
			mdic    <= '{ready: 1'b1, phyad: PHY_ADDR, default: '0};
			start_q <= 1'b0;
		end else begin
			start_q <= mdic_accept;
			if (mdic_accept) begin
				mdic.data  <= mdic_wr.data;
				mdic.regad <= mdic_wr.regad;
				mdic.op    <= mdic_wr.op;
				mdic.ready <= 1'b0;
			end else if (done_i) begin
				mdic.ready <= 1'b1;
				if (mdic.op == MDIO_OP_RD)
					mdic.data <= rd_data_i;  // PHY read result
			end
		end
	end

	always_comb begin
		cmd_o.start         = start_q;
		cmd_o.frame.f.st    = MDIO_ST;
		cmd_o.frame.f.op    = mdic.op;
		cmd_o.frame.f.phyad = PHY_ADDR;
		cmd_o.frame.f.regad = mdic.regad;
		cmd_o.frame.f.ta    = MDIO_TA;
		cmd_o.frame.f.data  = mdic.data;  // Don't care on reads
	end

	// Registered read mux
	always_ff @(posedge aclk) begin
		if (host_i.rd) begin
			case (host_i.addr)
				ADDR_MDIC: rdata_o <= mdic;
				ADDR_ICR:  rdata_o <= icr_i;
				ADDR_IMS:  rdata_o <= ims_i;
				default:   rdata_o <= '0;
			endcase
		end
	end

	assign icr_rd_o = host_i.rd && host_i.addr == ADDR_ICR;  // Clear on read
	assign ims_wr_o = host_i.wr && host_i.addr == ADDR_IMS;
	assign imc_wr_o = host_i.wr && host_i.addr == ADDR_IMC;
	assign wdata_o  = host_i.wdata;

	a_no_start_busy: assert property (@(posedge aclk) disable iff (!rst_n_i)
		cmd_o.start |-> !busy_i);

endmodule

`default_nettype wire

/* mdio_shifter.sv */
`timescale 1ns/1ns
`default_nettype none

module mdio_shifter #(
	parameter int MDC_DIV = 2
) (
	input  wire logic                aclk,
	input  wire logic                rst_n_i,
	input  wire mgmt_pkg::mdio_cmd_t cmd_i,
	output logic                     busy_o,
	output logic                     done_o,
	output logic [15:0]              rd_data_o,
	output logic                     mdc_o,
	input  wire logic                mdio_i,
	output logic                     mdio_o,
	output logic                     mdio_oe_o
);
	import mgmt_pkg::*;

	localparam int DIV_W    = $clog2(MDC_DIV);
	localparam int PRE_BITS = 32;
	localparam int TA_BIT   = PRE_BITS + 14;  // PHY owns the line from here on reads
	localparam int DATA_BIT = PRE_BITS + 16;

	logic [DIV_W-1:0] div_cnt;
	logic [5:0]       bit_cnt;
	logic [5:0]       bit_nxt;
	logic [31:0]      shift_q;
	logic             is_rd;
	logic             tick;
	logic             mdc_rise;
	logic             mdc_fall;

	assign tick     = div_cnt == DIV_W'(MDC_DIV - 1);
	assign mdc_rise = busy_o && tick && !mdc_o;
	assign mdc_fall = busy_o && tick && mdc_o;
	assign bit_nxt  = bit_cnt + 6'd1;

	always_ff @(posedge aclk) begin
		if (!rst_n_i) begin
			busy_o    <= 1'b0;
			done_o    <= 1'b0;
			mdc_o     <= 1'b0;
			mdio_o    <= 1'b1;
			mdio_oe_o <= 1'b0;
			div_cnt   <= '0;
			bit_cnt   <= '0;
		end else begin
			done_o <= 1'b0;
			if (!busy_o) begin
				if (cmd_i.start) begin
					busy_o    <= 1'b1;
					mdio_o    <= 1'b1;  // First preamble bit
					mdio_oe_o <= 1'b1;
					div_cnt   <= '0;
					bit_cnt   <= '0;
				end
			end else if (!tick) begin
				div_cnt <= div_cnt + 1'b1;
			end else begin
				div_cnt <= '0;
				mdc_o   <= !mdc_o;
				if (mdc_fall) begin
					if (bit_cnt == 6'd63) begin
						busy_o    <= 1'b0;
						done_o    <= 1'b1;
						mdio_o    <= 1'b1;
						mdio_oe_o <= 1'b0;
					end else begin
						bit_cnt   <= bit_nxt;
						mdio_o    <= (bit_nxt < 6'(PRE_BITS)) ? 1'b1 : shift_q[31];
						mdio_oe_o <= !(is_rd && bit_nxt >= 6'(TA_BIT));
					end
				end
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (!busy_o && cmd_i.start) begin
			shift_q <= cmd_i.frame.raw;
			is_rd   <= cmd_i.frame.f.op == MDIO_OP_RD;
		end else if (mdc_fall && bit_nxt >= 6'(PRE_BITS)) begin
			shift_q <= {shift_q[30:0], 1'b0};
		end
		// PHY data sampled on MDC rise
		if (mdc_rise && is_rd && bit_cnt >= 6'(DATA_BIT))
			rd_data_o <= {rd_data_o[14:0], mdio_i};
	end

	a_done_pulse: assert property (@(posedge aclk) disable iff (!rst_n_i)
		done_o |=> !done_o);

	a_oe_idle: assert property (@(posedge aclk) disable iff (!rst_n_i)
		!busy_o |-> !mdio_oe_o);

endmodule

`default_nettype wire

/* intr_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module intr_ctrl (
	input  wire logic        aclk,
	input  wire logic        rst_n_i,
	input  wire logic        mdac_i,
	input  wire logic        phy_int_i,
	input  wire logic        icr_rd_i,
	input  wire logic        ims_wr_i,
	input  wire logic        imc_wr_i,
	input  wire logic [31:0] wdata_i,
	output logic [31:0]      icr_o,
	output logic [31:0]      ims_o,
	output logic             intr_o
);
	import mgmt_pkg::*;

	logic [1:0]  phy_sync;
	logic [31:0] cause_set;

	always_comb begin
		cause_set               = '0;
		cause_set[CAUSE_MDAC]   = mdac_i;
		cause_set[CAUSE_PHYINT] = phy_sync[1];  // Level cause re-set while high
	end

	always_ff @(posedge aclk) begin
		if (!rst_n_i) begin
			phy_sync <= '0;
			icr_o    <= '0;
			ims_o    <= '0;
		end else begin
			phy_sync <= {phy_sync[0], phy_int_i};
			// New causes win over the read clear
			if (icr_rd_i)
				icr_o <= cause_set;
			else
				icr_o <= icr_o | cause_set;
			if (ims_wr_i)
				ims_o <= ims_o | wdata_i;
			else if (imc_wr_i)
				ims_o <= ims_o & ~wdata_i;
		end
	end

	assign intr_o = |(icr_o & ims_o);

	// Interrupt only rises after a new cause or a mask write
	a_intr_rise: assert property (@(posedge aclk) disable iff (!rst_n_i)
		$rose(intr_o) |-> $past(|cause_set || ims_wr_i));

endmodule

`default_nettype wire

/* mgmt_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mgmt_top #(
	parameter logic [4:0] PHY_ADDR = 5'h01,
	parameter int         MDC_DIV  = 2
) (
	input  wire logic                aclk,
	input  wire logic                rst_n_i,
	input  wire mgmt_pkg::host_req_t host_i,
	output logic [31:0]              rdata_o,
	output logic                     mdc_o,
	input  wire logic                mdio_i,
	output logic                     mdio_o,
	output logic                     mdio_oe_o,
	input  wire logic                phy_int_i,
	output logic                     intr_o
);
	import mgmt_pkg::*;

	mdio_cmd_t   cmd;
	logic        busy;
	logic        done;  // Also the MDAC cause
	logic [15:0] rd_data;
	logic [31:0] icr;
	logic [31:0] ims;
	logic        icr_rd;
	logic        ims_wr;
	logic        imc_wr;
	logic [31:0] wdata;

	mgmt_regs #(.PHY_ADDR(PHY_ADDR)) u_mgmt_regs (
		.aclk      (aclk),
		.rst_n_i   (rst_n_i),
		.host_i    (host_i),
		.rdata_o   (rdata_o),
		.cmd_o     (cmd),
		.busy_i    (busy),
		.done_i    (done),
		.rd_data_i (rd_data),
		.icr_i     (icr),
		.ims_i     (ims),
		.icr_rd_o  (icr_rd),
		.ims_wr_o  (ims_wr),
		.imc_wr_o  (imc_wr),
		.wdata_o   (wdata)
	);

	mdio_shifter #(.MDC_DIV(MDC_DIV)) u_mdio_shifter (
		.aclk      (aclk),
		.rst_n_i   (rst_n_i),
		.cmd_i     (cmd),
		.busy_o    (busy),
		.done_o    (done),
		.rd_data_o (rd_data),
		.mdc_o     (mdc_o),
		.mdio_i    (mdio_i),
		.mdio_o    (mdio_o),
		.mdio_oe_o (mdio_oe_o)
	);

	intr_ctrl u_intr_ctrl (
		.aclk      (aclk),
		.rst_n_i   (rst_n_i),
		.mdac_i    (done),
		.phy_int_i (phy_int_i),
		.icr_rd_i  (icr_rd),
		.ims_wr_i  (ims_wr),
		.imc_wr_i  (imc_wr),
		.wdata_i   (wdata),
		.icr_o     (icr),
		.ims_o     (ims),
		.intr_o    (intr_o)
	);

endmodule

`default_nettype wire

/* tb_mdio_phy.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mdio_phy #(
	parameter logic [4:0] PHY_ADDR = 5'h01
) (
	input  wire logic mdc_i,
	input  wire logic mdio_i,
	output logic      mdio_o
);
	logic [15:0] regs [32];
	logic [31:0] frame     = '0;
	logic [15:0] rd_word   = '0;
	logic        rd_active = 1'b0;
	logic        drive     = 1'b1;
	int          ones      = 0;
	int          pos       = 0;  // Next frame bit, 0 while hunting

	assign mdio_o = drive;

	initial begin
		for (int i = 0; i < 32; i++)
			regs[i] = 16'h5a00 + 16'(i);  // Keyed by register number
	end

	always @(posedge mdc_i) begin
		if (pos == 0) begin
			if (mdio_i) begin
				ones++;
			end else begin
				if (ones >= 32) begin
					frame = '0;  // ST high bit is this zero
					pos   = 1;
				end
				ones = 0;
			end
		end else begin
			frame[31-pos] = mdio_i;
			if (pos == 13 && frame[29:28] == 2'b10 && frame[27:23] == PHY_ADDR) begin
				rd_active = 1'b1;
				rd_word   = regs[frame[22:18]];
			end
			if (pos == 31) begin
				if (frame[29:28] == 2'b01 && frame[27:23] == PHY_ADDR)
					regs[frame[22:18]] = frame[15:0];
				rd_active = 1'b0;
				pos       = 0;
			end else begin
				pos++;
			end
		end
	end

	// Data changes after MDC falls, the DUT samples on the next rise
	always @(negedge mdc_i) begin
		if (rd_active && pos >= 16)
			drive = rd_word[31-pos];
		else
			drive = 1'b1;
	end

endmodule

`default_nettype wire

/* tb_mgmt_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mgmt_top;
	import mgmt_pkg::*;

	localparam int MDC_DIV  = 2;
	localparam int MAX_CMDS = 64;

	logic        aclk = 1'b0;
	logic        rst_n_i;
	host_req_t   host;
	logic [31:0] rdata;
	logic        mdc;
	logic        mdio_out;
	logic        mdio_in;
	logic        mdio_phy;
	logic        mdio_oe;
	logic        phy_int;
	logic        intr;

	byte         cmd_c [MAX_CMDS];
	logic [31:0] arg_a [MAX_CMDS];
	logic [31:0] arg_b [MAX_CMDS];
	int          n_cmds = 0;
	int          n_pass = 0;
	int          n_fail = 0;
	int          cycles = 0;
	int          limit  = 100000;

	always #20 aclk = ~aclk;

	mgmt_top #(.PHY_ADDR(5'h01), .MDC_DIV(MDC_DIV)) u_mgmt_top (
		.aclk      (aclk),
		.rst_n_i   (rst_n_i),
		.host_i    (host),
		.rdata_o   (rdata),
		.mdc_o     (mdc),
		.mdio_i    (mdio_in),
		.mdio_o    (mdio_out),
		.mdio_oe_o (mdio_oe),
		.phy_int_i (phy_int),
		.intr_o    (intr)
	);

	// DUT releases the line to the PHY for turnaround and read data
	assign mdio_in = mdio_oe ? mdio_out : mdio_phy;

	tb_mdio_phy #(.PHY_ADDR(5'h01)) u_phy (
		.mdc_i  (mdc),
		.mdio_i (mdio_in),
		.mdio_o (mdio_phy)
	);

	always @(posedge aclk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout after %0d cycles, the test sequence did not complete", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic reg_write(input logic [15:0] addr, input logic [31:0] data);
		host.wr    = 1'b1;
		host.addr  = addr;
		host.wdata = data;
		@(negedge aclk);
		host.wr = 1'b0;
	endtask

	task automatic reg_read(input logic [15:0] addr, output logic [31:0] data);
		host.rd   = 1'b1;
		host.addr = addr;
		@(negedge aclk);
		host.rd = 1'b0;
		data    = rdata;  // Registered one cycle after the strobe
	endtask

	task automatic pulse_phy_int();
		phy_int = 1'b1;
		@(negedge aclk);
		phy_int = 1'b0;
		repeat (3) @(negedge aclk);  // Synchronizer and ICR latency
	endtask

	task automatic show_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
	endtask

	initial begin
		int          fd;
		int          got;
		byte         c;
		string       line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] val;
		bit          ok;

		rst_n_i = 1'b0;
		host    = '0;
		phy_int = 1'b0;

		fd = $fopen("mgmt_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open mgmt_testdata.txt");
			n_fail++;
		end else begin
			while (n_cmds < MAX_CMDS) begin
				got = $fscanf(fd, " %c", c);
				if (got != 1)
					break;
				if (c == "#") begin
					got = $fgets(line, fd);
				end else begin
					got = $fscanf(fd, "%h %h", a, b);
					if (got != 2) begin
						$display("Missing values after command %c in mgmt_testdata.txt", c);
						n_fail++;
					end
					cmd_c[n_cmds] = c;
					arg_a[n_cmds] = a;
					arg_b[n_cmds] = b;
					n_cmds++;
				end
			end
			$fclose(fd);
		end
		limit = n_cmds * 64 * 2 * MDC_DIV * 2 + 16;

		repeat (8) @(negedge aclk);
		rst_n_i = 1'b1;

		ok = 1'b1;
		if ({mdc, mdio_oe, mdio_out, intr} !== 4'b0010) begin
			show_mismatch("{mdc_o,mdio_oe_o,mdio_o,intr_o}", 32'h2,
				{28'b0, mdc, mdio_oe, mdio_out, intr});
			ok = 1'b0;
		end
		if (ok)
			n_pass++;
		else
			n_fail++;
		$display("step reset idle pins %s", ok ? "ok" : "failed");

		for (int i = 0; i < n_cmds; i++) begin
			ok = 1'b1;
			case (cmd_c[i])
				"W": reg_write(arg_a[i][15:0], arg_b[i]);
				"R": begin
					reg_read(arg_a[i][15:0], val);
					if (val !== arg_b[i]) begin
						show_mismatch("rdata_o", arg_b[i], val);
						ok = 1'b0;
					end
				end
				"P": u_phy.regs[arg_a[i][4:0]] = arg_b[i][15:0];
				"Q": begin
					val = '0;
					while (!val[28])
						reg_read(ADDR_MDIC, val);
					if ({mdc, mdio_oe} !== 2'b00) begin
						show_mismatch("{mdc_o,mdio_oe_o}", 32'h0, {30'b0, mdc, mdio_oe});
						ok = 1'b0;
					end
				end
				"I": pulse_phy_int();
				"E": begin
					if (intr !== arg_a[i][0]) begin
						show_mismatch("intr_o", {31'b0, arg_a[i][0]}, {31'b0, intr});
						ok = 1'b0;
					end
				end
				"C": begin
					if (u_phy.regs[arg_a[i][4:0]] !== arg_b[i][15:0]) begin
						show_mismatch("phy_reg", {16'b0, arg_b[i][15:0]},
							{16'b0, u_phy.regs[arg_a[i][4:0]]});
						ok = 1'b0;
					end
				end
				default: begin
					$display("Unknown command %c at step %0d", cmd_c[i], i);
					ok = 1'b0;
				end
			endcase
			if (ok)
				n_pass++;
			else
				n_fail++;
			$display("step %0d %c %h %h %s", i, cmd_c[i], arg_a[i], arg_b[i],
				ok ? "ok" : "failed");
		end

		$display("Steps finished: %0d passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* mgmt_testdata.txt */
# Columns: command, first value, second value, all hex; text after # is ignored
# W addr data, R addr expected, P regad data, C regad expected, E intr_o level, Q and I take 0 0
R 0020 10200000   # MDIC ready after reset
E 0 0
W 0020 0405a5c3   # PHY write to regad 5
Q 0 0
C 05 a5c3
R 0020 1425a5c3
E 0 0             # MDAC pending but masked off
W 00d0 00000200
E 1 0
R 00c0 00000200
E 0 0
W 00d8 00000200
R 00d0 00000000
P 07 beef
W 0020 08070000   # PHY read of regad 7
Q 0 0
R 0020 1827beef
W 0020 04031111
W 0020 04032222   # Issued while the first frame runs
Q 0 0
C 03 1111
R 0020 14231111
R 00c0 00000200
W 00d0 00001000
I 0 0
E 1 0
R 00c0 00001000
E 0 0
W 00d8 00001000
I 0 0
E 0 0
R 00c0 00001000

/* mgmt_top.f */
mgmt_pkg.sv
mgmt_regs.sv
mdio_shifter.sv
intr_ctrl.sv
mgmt_top.sv
tb_mdio_phy.sv
tb_mgmt_top.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mgmt_top -f mgmt_top.f -o tb_mgmt_top \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_mgmt_top > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
